/* all.f */
rtl/rr_pkg.sv
rtl/rr_log_fifo.sv
rtl/rr_channel_recorder.sv
rtl/rr_trace_packer.sv
rtl/rr_record_top.sv
testbench/tb_rr_record_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the record path testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f all.f --top-module tb_rr_record_top -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log

grep -qx "all tests passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* testbench/tb_rr_record_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rr_record_top;

  localparam int LOG_DEPTH    = 4;
  localparam int MODE_STAGES  = 4;
  localparam int CLK_PERIOD   = 20;
  localparam int RST_CYCLES   = 8;
  // Quiet cycles on each side of an enable toggle
  localparam int PAUSE        = MODE_STAGES + 2;
  localparam int OFF_CYCLES   = 150;
  localparam int ON_CYCLES    = 300;
  localparam int STALL_CYCLES = 60;
  localparam int DRAIN_CYCLES = 100;
  localparam int TOTAL_CYCLES = RST_CYCLES + 2 * OFF_CYCLES + 2 * ON_CYCLES + STALL_CYCLES
                                + 4 * PAUSE + DRAIN_CYCLES;
  localparam int WATCHDOG_NS  = TOTAL_CYCLES * 3 * CLK_PERIOD;

  logic              clk = 1'b0;
  logic              i_rst;
  logic              i_record_en;
  logic              i_ocl_valid;
  rr_pkg::rr_req_t   i_ocl_req;
  logic              o_ocl_ready;
  logic              o_cl_ocl_valid;
  rr_pkg::rr_req_t   o_cl_ocl_req;
  logic              i_cl_ocl_ready;
  logic              i_sda_valid;
  rr_pkg::rr_req_t   i_sda_req;
  logic              o_sda_ready;
  logic              o_cl_sda_valid;
  rr_pkg::rr_req_t   o_cl_sda_req;
  logic              i_cl_sda_ready;
  logic              o_trace_valid;
  rr_pkg::rr_trace_t o_trace;
  logic              i_trace_ready;

  // Expected log contents per channel, oldest first
  rr_pkg::rr_req_t   ocl_q [$];
  rr_pkg::rr_req_t   sda_q [$];
  // Queue state as seen by the assertions
  rr_pkg::rr_req_t   ocl_front;
  rr_pkg::rr_req_t   sda_front;
  int                ocl_count;
  int                sda_count;
  logic [15:0]       exp_seq;
  logic              held_valid;
  rr_pkg::rr_trace_t held_word;

  // Mid-cycle captures, stable across the next rising edge
  logic              ocl_hs;
  logic              sda_hs;
  logic              trace_hs;
  logic              trace_valid_n;
  rr_pkg::rr_trace_t trace_n;

  logic              en_settled;
  logic              rec_on;
  logic              saw_gate;
  logic [31:0]       lcg_state;

  assign rec_on = en_settled && i_record_en;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rr_record_top #(
    .LOG_DEPTH   (LOG_DEPTH),
    .MODE_STAGES (MODE_STAGES)
  ) DUT (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_record_en    (i_record_en),
    .i_ocl_valid    (i_ocl_valid),
    .i_ocl_req      (i_ocl_req),
    .o_ocl_ready    (o_ocl_ready),
    .o_cl_ocl_valid (o_cl_ocl_valid),
    .o_cl_ocl_req   (o_cl_ocl_req),
    .i_cl_ocl_ready (i_cl_ocl_ready),
    .i_sda_valid    (i_sda_valid),
    .i_sda_req      (i_sda_req),
    .o_sda_ready    (o_sda_ready),
    .o_cl_sda_valid (o_cl_sda_valid),
    .o_cl_sda_req   (o_cl_sda_req),
    .i_cl_sda_ready (i_cl_sda_ready),
    .o_trace_valid  (o_trace_valid),
    .o_trace        (o_trace),
    .i_trace_ready  (i_trace_ready)
  );

  ////////////////////////////////////////
  // Random numbers and failure exits
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // True with a chance of pct percent
  function automatic bit chance(input int pct);
    return int'((lcg_next() >> 8) % 32'd100) < pct;
  endfunction

  function automatic rr_pkg::rr_req_t rand_req();
    rr_pkg::rr_req_t r;
    r.addr = lcg_next();
    r.data = lcg_next();
    return r;
  endfunction

  task automatic fail_now();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input string exp_s, input string act_s);
    $display("** Error at %0t: %s expected %s got %s", $time, sig, exp_s, act_s);
    fail_now();
  endtask

  ////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////

  // Handshakes are settled by mid-cycle
  always @(negedge clk) begin
    ocl_hs        = i_ocl_valid && o_ocl_ready;
    sda_hs        = i_sda_valid && o_sda_ready;
    trace_hs      = o_trace_valid && i_trace_ready;
    trace_valid_n = o_trace_valid;
    trace_n       = o_trace;
    // A full log holding the shell off
    if (rec_on && ((i_cl_ocl_ready && !o_ocl_ready) || (i_cl_sda_ready && !o_sda_ready))) begin
      saw_gate = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (i_rst) begin
      ocl_q.delete();
      sda_q.delete();
      exp_seq    <= '0;
      held_valid <= 1'b0;
      ocl_count  <= 0;
      sda_count  <= 0;
      ocl_front  <= '0;
      sda_front  <= '0;
    end else begin
      // Trace transfer retires the oldest entry of each masked channel
      if (trace_hs) begin
        if (trace_n.mask[rr_pkg::CH_OCL] && ocl_q.size() != 0) begin
          void'(ocl_q.pop_front());
        end
        if (trace_n.mask[rr_pkg::CH_SDA] && sda_q.size() != 0) begin
          void'(sda_q.pop_front());
        end
        exp_seq <= exp_seq + 16'd1;
      end
      // Only handshakes under a settled enable are logged
      if (rec_on && ocl_hs) begin
        ocl_q.push_back(i_ocl_req);
      end
      if (rec_on && sda_hs) begin
        sda_q.push_back(i_sda_req);
      end
      held_valid <= trace_valid_n && !i_trace_ready;
      held_word  <= trace_n;
      ocl_count  <= ocl_q.size();
      sda_count  <= sda_q.size();
      ocl_front  <= (ocl_q.size() != 0) ? ocl_q[0] : '0;
      sda_front  <= (sda_q.size() != 0) ? sda_q[0] : '0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Requests reach the user circuit untouched
  assert property (@(posedge clk) {o_cl_ocl_valid, o_cl_ocl_req} == {i_ocl_valid, i_ocl_req})
    else report_mismatch("o_cl_ocl_req", $sformatf("%b %h", $sampled(i_ocl_valid),
      $sampled(i_ocl_req)), $sformatf("%b %h", $sampled(o_cl_ocl_valid), $sampled(o_cl_ocl_req)));
  assert property (@(posedge clk) {o_cl_sda_valid, o_cl_sda_req} == {i_sda_valid, i_sda_req})
    else report_mismatch("o_cl_sda_req", $sformatf("%b %h", $sampled(i_sda_valid),
      $sampled(i_sda_req)), $sformatf("%b %h", $sampled(o_cl_sda_valid), $sampled(o_cl_sda_req)));

  // Shell ready never runs ahead of the user circuit
  assert property (@(posedge clk) disable iff (i_rst) !i_cl_ocl_ready |-> !o_ocl_ready)
    else report_mismatch("o_ocl_ready", "0", "1");
  assert property (@(posedge clk) disable iff (i_rst) !i_cl_sda_ready |-> !o_sda_ready)
    else report_mismatch("o_sda_ready", "0", "1");

  // Recording off means no gating at all
  assert property (@(posedge clk) disable iff (i_rst)
    (en_settled && !i_record_en) |-> (o_ocl_ready == i_cl_ocl_ready))
    else report_mismatch("o_ocl_ready", $sformatf("%b", $sampled(i_cl_ocl_ready)),
      $sformatf("%b", $sampled(o_ocl_ready)));
  assert property (@(posedge clk) disable iff (i_rst)
    (en_settled && !i_record_en) |-> (o_sda_ready == i_cl_sda_ready))
    else report_mismatch("o_sda_ready", $sformatf("%b", $sampled(i_cl_sda_ready)),
      $sformatf("%b", $sampled(o_sda_ready)));

  assert property (@(posedge clk) disable iff (i_rst)
    (o_trace_valid && i_trace_ready) |-> (o_trace.mask != '0))
    else report_mismatch("o_trace.mask", "nonzero", "00");

  // Each masked slot must match the oldest queued request
  assert property (@(posedge clk) disable iff (i_rst)
    (o_trace_valid && i_trace_ready && o_trace.mask[rr_pkg::CH_OCL])
    |-> (ocl_count != 0 && o_trace.slot[rr_pkg::CH_OCL] == ocl_front))
    else report_mismatch("o_trace.slot[ocl]", $sformatf("%h (%0d queued)",
      $sampled(ocl_front), $sampled(ocl_count)), $sformatf("%h", $sampled(o_trace.slot[0])));
  assert property (@(posedge clk) disable iff (i_rst)
    (o_trace_valid && i_trace_ready && o_trace.mask[rr_pkg::CH_SDA])
    |-> (sda_count != 0 && o_trace.slot[rr_pkg::CH_SDA] == sda_front))
    else report_mismatch("o_trace.slot[sda]", $sformatf("%h (%0d queued)",
      $sampled(sda_front), $sampled(sda_count)), $sformatf("%h", $sampled(o_trace.slot[1])));

  assert property (@(posedge clk) disable iff (i_rst)
    (o_trace_valid && i_trace_ready) |-> (o_trace.seq == exp_seq))
    else report_mismatch("o_trace.seq", $sformatf("%0d", $sampled(exp_seq)),
      $sformatf("%0d", $sampled(o_trace.seq)));

  // Stalled word holds still
  assert property (@(posedge clk) disable iff (i_rst)
    held_valid |-> (o_trace_valid && o_trace == held_word))
    else report_mismatch("o_trace", $sformatf("%b %h", 1'b1, $sampled(held_word)),
      $sformatf("%b %h", $sampled(o_trace_valid), $sampled(o_trace)));

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One cycle of traffic, a pending request is held until it transfers
  task automatic step(input bit traffic, input int valid_pct, input int cl_pct, input int tr_pct);
    @(posedge clk);
    #1;
    if (!i_ocl_valid || ocl_hs) begin
      i_ocl_valid = traffic && chance(valid_pct);
      i_ocl_req   = i_ocl_valid ? rand_req() : '0;
    end
    if (!i_sda_valid || sda_hs) begin
      i_sda_valid = traffic && chance(valid_pct);
      i_sda_req   = i_sda_valid ? rand_req() : '0;
    end
    i_cl_ocl_ready = chance(cl_pct);
    i_cl_sda_ready = chance(cl_pct);
    i_trace_ready  = chance(tr_pct);
  endtask

  // Quiet bus on both sides of the change
  task automatic toggle_record(input bit en);
    while (i_ocl_valid || i_sda_valid) begin
      step(1'b0, 0, 80, 80);
    end
    repeat (PAUSE) step(1'b0, 0, 80, 80);
    en_settled  = 1'b0;
    i_record_en = en;
    repeat (PAUSE) step(1'b0, 0, 80, 80);
    en_settled  = 1'b1;
  endtask

  initial begin
    lcg_state      = 32'hadc1;
    i_rst          = 1'b1;
    i_record_en    = 1'b0;
    i_ocl_valid    = 1'b0;
    i_ocl_req      = '0;
    i_cl_ocl_ready = 1'b0;
    i_sda_valid    = 1'b0;
    i_sda_req      = '0;
    i_cl_sda_ready = 1'b0;
    i_trace_ready  = 1'b0;
    ocl_hs         = 1'b0;
    sda_hs         = 1'b0;
    en_settled     = 1'b1;
    saw_gate       = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    i_rst = 1'b0;
    repeat (OFF_CYCLES) step(1'b1, 60, 70, 70);
    toggle_record(1'b1);
    repeat (ON_CYCLES) step(1'b1, 60, 70, 60);
    // Long trace stall fills both logs
    repeat (STALL_CYCLES) step(1'b1, 90, 90, 0);
    repeat (ON_CYCLES) step(1'b1, 60, 70, 80);
    toggle_record(1'b0);
    repeat (OFF_CYCLES) step(1'b1, 60, 70, 70);
    // Drain, the watchdog bounds this loop
    while (i_ocl_valid || i_sda_valid || ocl_q.size() != 0 || sda_q.size() != 0) begin
      step(1'b0, 0, 100, 100);
    end
    repeat (4) step(1'b0, 0, 100, 100);
    if (!o_trace_valid && saw_gate) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("run ended with %s", saw_gate ? "an unexpected trace word"
        : "no shell ready drop under trace back-pressure");
      fail_now();
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: logged requests did not drain within %0d ns", WATCHDOG_NS);
    fail_now();
  end

endmodule

`default_nettype wire

/* rtl/rr_record_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rr_record_top #(
  parameter int LOG_DEPTH   = 4,
  parameter int MODE_STAGES = 4
) (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_record_en,
  // ocl, shell side
  input  logic              i_ocl_valid,
  input  rr_pkg::rr_req_t   i_ocl_req,
  output logic              o_ocl_ready,
  // ocl, user circuit side
  output logic              o_cl_ocl_valid,
  output rr_pkg::rr_req_t   o_cl_ocl_req,
  input  logic              i_cl_ocl_ready,
  // sda, shell side
  input  logic              i_sda_valid,
  input  rr_pkg::rr_req_t   i_sda_req,
  output logic              o_sda_ready,
  // sda, user circuit side
  output logic              o_cl_sda_valid,
  output rr_pkg::rr_req_t   o_cl_sda_req,
  input  logic              i_cl_sda_ready,
  // Trace output
  output logic              o_trace_valid,
  output rr_pkg::rr_trace_t o_trace,
  input  logic              i_trace_ready
);

  // Record enable pipeline
  logic            record_pipe [MODE_STAGES];
  logic            record_en_q;

  // Log heads between recorders and packer
  logic            ocl_log_valid;
  rr_pkg::rr_req_t ocl_log_head;
  logic            ocl_log_pop;
  logic            sda_log_valid;
  rr_pkg::rr_req_t sda_log_head;
  logic            sda_log_pop;

  ////////////////////////////////////////
  // Record enable staging
  ////////////////////////////////////////

  // Both channels must switch on the same edge
  // Stages also give placement slack towards far recorders
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < MODE_STAGES; i++) begin
        record_pipe[i] <= 1'b0;
      end
    end else begin
      record_pipe[0] <= i_record_en;
      for (int i = 1; i < MODE_STAGES; i++) begin
        record_pipe[i] <= record_pipe[i-1];
      end
    end
  end

  assign record_en_q = record_pipe[MODE_STAGES-1];

  ////////////////////////////////////////
  // Channel recorders
  ////////////////////////////////////////

  rr_channel_recorder #(
    .LOG_DEPTH (LOG_DEPTH)
  ) ocl_recorder (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_record_en (record_en_q),
    .i_valid     (i_ocl_valid),
    .i_req       (i_ocl_req),
    .o_ready     (o_ocl_ready),
    .o_cl_valid  (o_cl_ocl_valid),
    .o_cl_req    (o_cl_ocl_req),
    .i_cl_ready  (i_cl_ocl_ready),
    .o_log_valid (ocl_log_valid),
    .o_log_head  (ocl_log_head),
    .i_log_pop   (ocl_log_pop)
  );

  rr_channel_recorder #(
    .LOG_DEPTH (LOG_DEPTH)
  ) sda_recorder (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_record_en (record_en_q),
    .i_valid     (i_sda_valid),
    .i_req       (i_sda_req),
    .o_ready     (o_sda_ready),
    .o_cl_valid  (o_cl_sda_valid),
    .o_cl_req    (o_cl_sda_req),
    .i_cl_ready  (i_cl_sda_ready),
    .o_log_valid (sda_log_valid),
    .o_log_head  (sda_log_head),
    .i_log_pop   (sda_log_pop)
  );

  ////////////////////////////////////////
  // Merge into trace words
  ////////////////////////////////////////

  // Single group2 node, ocl and sda
  rr_trace_packer trace_packer (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_ocl_valid   (ocl_log_valid),
    .i_ocl_head    (ocl_log_head),
    .o_ocl_pop     (ocl_log_pop),
    .i_sda_valid   (sda_log_valid),
    .i_sda_head    (sda_log_head),
    .o_sda_pop     (sda_log_pop),
    .o_trace_valid (o_trace_valid),
    .o_trace       (o_trace),
    .i_trace_ready (i_trace_ready)
  );

endmodule

`default_nettype wire

/* rtl/rr_trace_packer.sv */
`timescale 1ns/10ps
`default_nettype none

module rr_trace_packer (
  input  logic              clk,
  input  logic              i_rst,
  // ocl log head
  input  logic              i_ocl_valid,
  input  rr_pkg::rr_req_t   i_ocl_head,
  output logic              o_ocl_pop,
  // sda log head
  input  logic              i_sda_valid,
  input  rr_pkg::rr_req_t   i_sda_head,
  output logic              o_sda_pop,
  // Trace output with valid/ready handshake
  output logic              o_trace_valid,
  output rr_pkg::rr_trace_t o_trace,
  input  logic              i_trace_ready
);

  // Heads gathered in channel order
  logic [rr_pkg::NUM_CH-1:0]   head_valid;
  rr_pkg::rr_req_t             head_req [rr_pkg::NUM_CH];

  // Output register
  logic                        trace_valid_q;
  rr_pkg::rr_trace_t           trace_q;
  logic [rr_pkg::SEQ_W-1:0]    seq_q;

  // Load control
  logic                        reg_free;
  logic                        load;
  rr_pkg::rr_trace_t           trace_nxt;

  ////////////////////////////////////////
  // Gather heads by channel
  ////////////////////////////////////////

  always_comb begin
    head_valid                   = '0;
    head_valid[rr_pkg::CH_OCL]   = i_ocl_valid;
    head_valid[rr_pkg::CH_SDA]   = i_sda_valid;
    head_req[rr_pkg::CH_OCL]     = i_ocl_head;
    head_req[rr_pkg::CH_SDA]     = i_sda_head;
  end

  ////////////////////////////////////////
  // Load decision
  ////////////////////////////////////////

  // Register empty, or its word leaves on this edge
  assign reg_free = !trace_valid_q || i_trace_ready;

  // Need at least one head to make a word
  assign load = reg_free && (|head_valid);

  // Each present head is consumed together with the load
  assign o_ocl_pop = load && head_valid[rr_pkg::CH_OCL];
  assign o_sda_pop = load && head_valid[rr_pkg::CH_SDA];

  ////////////////////////////////////////
  // Next trace word
  ////////////////////////////////////////

  always_comb begin
    // Absent slots stay zero
    trace_nxt     = '0;
    trace_nxt.seq = seq_q;
    for (int ch = 0; ch < rr_pkg::NUM_CH; ch++) begin
      if (head_valid[ch]) begin
        trace_nxt.mask[ch] = 1'b1;
        trace_nxt.slot[ch] = head_req[ch];
      end
    end
  end

  ////////////////////////////////////////
  // Output register and sequence
  ////////////////////////////////////////

  // Control state
  always_ff @(posedge clk) begin
    if (i_rst) begin
      trace_valid_q <= 1'b0;
      seq_q         <= '0;
    end else begin
      if (load) begin
        trace_valid_q <= 1'b1;
        // One step per word and wraps at the top
        seq_q         <= seq_q + 1'b1;
      end else if (i_trace_ready) begin
        trace_valid_q <= 1'b0;
      end
    end
  end

  // Payload register, loads with each new word
  always_ff @(posedge clk) begin
    if (load) begin
      trace_q <= trace_nxt;
    end
  end

  assign o_trace_valid = trace_valid_q;
  assign o_trace       = trace_q;

  // Back-pressured word must not move
  assert property (@(posedge clk) disable iff (i_rst)
    (o_trace_valid && !i_trace_ready) |=> (o_trace_valid && $stable(o_trace)))
    else $error("trace word changed under back-pressure");

endmodule

`default_nettype wire

/* rtl/rr_channel_recorder.sv */
`timescale 1ns/10ps
`default_nettype none

module rr_channel_recorder #(
  parameter int LOG_DEPTH = 4
) (
  input  logic            clk,
  input  logic            i_rst,
  // Staged record enable, shared with the other channel
  input  logic            i_record_en,
  // Shell side
  input  logic            i_valid,
  input  rr_pkg::rr_req_t i_req,
  output logic            o_ready,
  // User circuit side
  output logic            o_cl_valid,
  output rr_pkg::rr_req_t o_cl_req,
  input  logic            i_cl_ready,
  // Log head towards the trace packer
  output logic            o_log_valid,
  output rr_pkg::rr_req_t o_log_head,
  input  logic            i_log_pop
);

  logic log_full;
  logic log_empty;
  logic log_gate;
  logic accepted;
  logic log_push;

  ////////////////////////////////////////
  // Pass-through
  ////////////////////////////////////////

  // Request reaches the user circuit unchanged in the same cycle
  assign o_cl_valid = i_valid;
  assign o_cl_req   = i_req;

  // Hold the shell off only when a handshake could not be logged
  assign log_gate = i_record_en && log_full;
  assign o_ready  = i_cl_ready && !log_gate;

  // Shell side handshake completes this edge
  assign accepted = i_valid && o_ready;

  ////////////////////////////////////////
  // Logging
  ////////////////////////////////////////

  // Every accepted request is logged while recording
  assign log_push = i_record_en && accepted;

  rr_log_fifo #(
    .LOG_DEPTH (LOG_DEPTH)
  ) log_fifo (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_push  (log_push),
    .i_din   (i_req),
    .i_pop   (i_log_pop),
    .o_dout  (o_log_head),
    .o_empty (log_empty),
    .o_full  (log_full)
  );

  // Head is valid whenever an entry waits
  assign o_log_valid = !log_empty;

  // Full log while recording must stall the shell, or a handshake is lost
  assert property (@(posedge clk) disable iff (i_rst)
    (i_record_en && log_full) |-> !o_ready)
    else $error("shell ready high with recording on and log full");

  // A logged request shows up at the head on the next cycle
  assert property (@(posedge clk) disable iff (i_rst)
    log_push |=> o_log_valid)
    else $error("logged request missing from log head");

endmodule

`default_nettype wire

/* rtl/rr_log_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module rr_log_fifo #(
  parameter int LOG_DEPTH = 4
) (
  input  logic            clk,
  input  logic            i_rst,
  input  logic            i_push,
  input  rr_pkg::rr_req_t i_din,
  input  logic            i_pop,
  output rr_pkg::rr_req_t o_dout,
  output logic            o_empty,
  output logic            o_full
);

  // Pointers wrap naturally, depth is a power of two
  localparam int PTR_W = $clog2(LOG_DEPTH);
  // Count needs one more value than the pointers
  localparam int CNT_W = $clog2(LOG_DEPTH + 1);

  rr_pkg::rr_req_t  mem [LOG_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Entry lands at the tail, visible at the head next cycle
  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_din;
    end
  end

  // Head read straight from the array, no output register
  assign o_dout = mem[rd_ptr];

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (i_push && !i_pop) begin
        count <= count + 1'b1;
      end else if (!i_push && i_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(LOG_DEPTH));

  // Overflow is only legal when the head leaves on the same edge
  assert property (@(posedge clk) disable iff (i_rst) (i_push && o_full) |-> i_pop)
    else $error("log fifo pushed while full");

  // Consumer must only pop a present head
  assert property (@(posedge clk) disable iff (i_rst) i_pop |-> !o_empty)
    else $error("log fifo popped while empty");

endmodule

`default_nettype wire

/* rtl/rr_pkg.sv */
`default_nettype none

package rr_pkg;

  ////////////////////////////////////////
  // Request widths
  ////////////////////////////////////////

  // AXI-lite style address of one request
  parameter int ADDR_W = 32;
  // Write data carried with the request
  parameter int DATA_W = 32;
  // Running sequence number stamped on every trace word
  parameter int SEQ_W = 16;

  ////////////////////////////////////////
  // Channel order
  ////////////////////////////////////////

  // Bit index in the trace mask and slot index in the trace word
  // Order follows the shell interface order, ocl first
  typedef enum logic [0:0] {
    CH_OCL = 1'b0,
    CH_SDA = 1'b1
  } rr_chan_e;

  // One log slot per enum entry
  parameter int NUM_CH = int'(CH_SDA) + 1;

  ////////////////////////////////////////
  // Payload structs
  ////////////////////////////////////////

  // One request as seen on the shell side
  // Also the log entry, since a logged handshake is just its payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } rr_req_t;

  // Packed trace word handed to the storage side
  // Slots of absent channels are zero and their mask bits low
  typedef struct packed {
    // Stamped at load time, wraps at 2**SEQ_W
    logic [SEQ_W-1:0] seq;
    // One bit per channel, set when that slot holds a logged request
    logic [NUM_CH-1:0] mask;
    // Indexed by rr_chan_e
    rr_req_t [NUM_CH-1:0] slot;
  } rr_trace_t;

endpackage

`default_nettype wire
